// ==== include/uart_str_defs.svh ====
// UART string link constants
// Line timing, stop-bit count, frame marker and string capacity shared by the
// RTL and the testbench

`ifndef UART_STR_DEFS_SVH
`define UART_STR_DEFS_SVH

// ######################################################################
// Line timing
// ######################################################################
`define UART_CLK_FREQ       10_000_000                              // System clock in Hz
`define UART_BAUD_RATE      115_200                                 // Default line rate
`define UART_BIT_CYCLES     (`UART_CLK_FREQ / `UART_BAUD_RATE)      // Clocks per bit, 86 here
`define UART_TX_STOP_BITS   2                                       // Stop bits on the transmit side

// ######################################################################
// String framing
// ######################################################################
`define STR_MARKER          8'h26                                   // The "&" character
`define STR_MAX_LEN         128                                     // Payload capacity in bytes

`endif

// ==== logic/uart_str_pkg.sv ====
// UART string link package
// Holds the string buffer type that the framer, deframer and top level share

`default_nettype none

`include "uart_str_defs.svh"

package uart_str_pkg;

	// One string buffer seen either as the flat port word or as its characters.
	// Character k sits in bits 8k+7 down to 8k of the flat word
	typedef union packed {
		logic [`STR_MAX_LEN*8-1:0]      word;      // Flat view used on ports
		logic [`STR_MAX_LEN-1:0][7:0]   bytes;     // Byte view used by the framers
	} str_buf_u;

endpackage

`default_nettype wire

// ==== logic/uart_tx.sv ====
// UART byte transmitter
// Sends a start bit, eight data bits LSB first and STOP_BITS stop bits per
// request, with the line idling high

`timescale 1ns/1ns
`default_nettype none

`include "uart_str_defs.svh"

module uart_tx #(
	parameter int BIT_CYCLES = `UART_BIT_CYCLES,
	parameter int STOP_BITS  = `UART_TX_STOP_BITS
) (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire  [7:0]  byte_data,
	input  wire         byte_req,
	output logic        tx,
	output logic        byte_done
);

	localparam int FRAME_BITS = 1 + 8 + STOP_BITS;               // Start, data and stop bits
	localparam int SR_W       = 8 + STOP_BITS;                   // Bits still to go after start
	localparam int CNT_W      = $clog2(BIT_CYCLES + 1);
	localparam int IDX_W      = $clog2(FRAME_BITS);

	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_CYCLES - 1);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(FRAME_BITS - 1);

	logic               busy;
	logic [CNT_W-1:0]   cyc_cnt;                                 // Clock count inside one bit
	logic [IDX_W-1:0]   bit_idx;                                 // Bit position within the frame
	logic [SR_W-1:0]    shift_sr;                                // Data then stop bits, LSB next
	logic               bit_end;
	logic               last_bit;

	assign bit_end   = busy && (cyc_cnt == CNT_LAST);
	assign last_bit  = (bit_idx == IDX_LAST);
	assign byte_done = bit_end && last_bit;                      // Last cycle of the last stop bit

	// ######################################################################
	// Bit timing and line driver
	// ######################################################################
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			cyc_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else if (!busy) begin
			if (byte_req) begin
				busy    <= 1'b1;
				cyc_cnt <= '0;
				bit_idx <= '0;
				tx      <= 1'b0;                             // Start bit begins on the next cycle
			end
		end else if (bit_end) begin
			cyc_cnt <= '0;
			if (last_bit) begin
				busy <= 1'b0;
				tx   <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 1'b1;
				tx      <= shift_sr[0];
			end
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	// Ones shift in from the top so the stop bits follow the data
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req)
			shift_sr <= {{STOP_BITS{1'b1}}, byte_data};
		else if (bit_end && !last_bit)
			shift_sr <= {1'b1, shift_sr[SR_W-1:1]};
	end

	// The framer waits for byte_done before raising the next request
	a_req_when_idle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !busy
	) else $error("uart_tx: byte_req arrived in the middle of a frame");

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
// UART byte receiver
// Synchronizes the serial line, finds the falling start edge and samples each
// bit at its middle; a byte is reported only when its stop bit is high

`timescale 1ns/1ns
`default_nettype none

`include "uart_str_defs.svh"

module uart_rx #(
	parameter int BIT_CYCLES = `UART_BIT_CYCLES
) (
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire         rx,
	output logic [7:0]  byte_data,
	output logic        byte_vld
);

	localparam int CNT_W = $clog2(BIT_CYCLES + 1);
	// The synchronizer and edge register add about three cycles of lag
	localparam int MID   = (BIT_CYCLES / 2 > 3) ? BIT_CYCLES / 2 - 3 : 0;

	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_CYCLES - 1);
	localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(MID);

	localparam logic [1:0] S_IDLE  = 2'd0,
	                       S_START = 2'd1,
	                       S_DATA  = 2'd2,
	                       S_STOP  = 2'd3;

	logic               rx_meta;
	logic               rx_sync;
	logic               rx_prev;
	logic [1:0]         state;
	logic [CNT_W-1:0]   cyc_cnt;
	logic [2:0]         bit_idx;
	logic [7:0]         data_sr;
	logic               start_edge;
	logic               bit_end;

	assign start_edge = rx_prev && !rx_sync;
	assign bit_end    = (cyc_cnt == CNT_LAST);
	assign byte_data  = data_sr;

	// ######################################################################
	// Line synchronizer
	// ######################################################################
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;                                     // Idle line is high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// ######################################################################
	// Frame sampling
	// ######################################################################
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			cyc_cnt  <= '0;
			bit_idx  <= '0;
			byte_vld <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_edge) begin
						state   <= S_START;
						cyc_cnt <= '0;
					end
				end
				S_START: begin
					if (cyc_cnt == MID_CNT) begin
						cyc_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? S_IDLE : S_DATA;  // A glitch returns to idle
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						cyc_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				default: begin
					if (bit_end) begin
						byte_vld <= rx_sync;                     // Low stop bit drops the byte
						state    <= S_IDLE;
					end else begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Data arrives LSB first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && bit_end)
			data_sr <= {rx_sync, data_sr[7:1]};
	end

endmodule

`default_nettype wire

// ==== logic/str_frame_tx.sv ====
// String framer for the transmit side
// Latches a string and its length, then feeds "&&", the payload bytes and
// "&&" to the byte transmitter one request at a time

`timescale 1ns/1ns
`default_nettype none

`include "uart_str_defs.svh"

module str_frame_tx import uart_str_pkg::*; (
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire str_buf_u   tx_string,
	input  wire  [7:0]      tx_length,
	input  wire             tx_req,
	output logic            tx_busy,
	output logic            tx_done,
	output logic [7:0]      byte_data,
	output logic            byte_req,
	input  wire             byte_done
);

	localparam int         IDX_W  = $clog2(`STR_MAX_LEN);
	localparam logic [7:0] MARKER = `STR_MARKER;

	localparam logic [6:0] ST_IDLE    = 7'b000_0001,
	                       ST_OPEN1   = 7'b000_0010,
	                       ST_OPEN2   = 7'b000_0100,
	                       ST_CONTENT = 7'b000_1000,
	                       ST_CLOSE1  = 7'b001_0000,
	                       ST_CLOSE2  = 7'b010_0000,
	                       ST_FINISH  = 7'b100_0000;

	logic [6:0]     state;
	logic [7:0]     byte_cnt;                                    // Next payload byte to send
	logic [7:0]     len_buf;
	str_buf_u       str_buf;
	logic           accept;
	logic           payload_left;

	assign accept       = (state == ST_IDLE) && tx_req && (tx_length != 8'd0);
	assign payload_left = (byte_cnt != len_buf);
	assign tx_busy      = (state != ST_IDLE);
	assign tx_done      = (state == ST_FINISH);

	// ######################################################################
	// Framing state machine
	// ######################################################################
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= ST_IDLE;
			byte_cnt  <= 8'd0;
			byte_data <= 8'd0;
			byte_req  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state     <= ST_OPEN1;
						byte_cnt  <= 8'd0;
						byte_data <= MARKER;                     // First opening marker
						byte_req  <= 1'b1;
					end
				end
				ST_OPEN1: begin
					if (byte_done) begin
						state     <= ST_OPEN2;
						byte_data <= MARKER;
						byte_req  <= 1'b1;
					end
				end
				ST_OPEN2, ST_CONTENT: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (payload_left) begin
							state     <= ST_CONTENT;
							byte_data <= str_buf.bytes[byte_cnt[IDX_W-1:0]];
							byte_cnt  <= byte_cnt + 8'd1;
						end else begin
							state     <= ST_CLOSE1;
							byte_data <= MARKER;
						end
					end
				end
				ST_CLOSE1: begin
					if (byte_done) begin
						state     <= ST_CLOSE2;
						byte_data <= MARKER;
						byte_req  <= 1'b1;
					end
				end
				ST_CLOSE2: begin
					if (byte_done)
						state <= ST_FINISH;
				end
				default: state <= ST_IDLE;                       // Finish lasts one cycle
			endcase
		end
	end

	// The caller may change its inputs once the string is taken
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_buf <= tx_string;
			len_buf <= tx_length;
		end
	end

	// Done follows the last stop bit of the closing marker and ends the busy period
	a_done_pulse: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(byte_done) ##1 (!tx_done && !tx_busy)
	) else $error("str_frame_tx: tx_done is not a single pulse after the last byte");

endmodule

`default_nettype wire

// ==== logic/str_frame_rx.sv ====
// String deframer for the receive side
// Hunts for "&&", stores payload bytes until the closing "&&" and keeps a
// lone "&" as data; storage stops at the buffer capacity

`timescale 1ns/1ns
`default_nettype none

`include "uart_str_defs.svh"

module str_frame_rx import uart_str_pkg::*; (
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire  [7:0]      byte_data,
	input  wire             byte_vld,
	output str_buf_u        rx_string,
	output logic [7:0]      rx_length,
	output logic            rx_busy,
	output logic            rx_done
);

	localparam int         IDX_W      = $clog2(`STR_MAX_LEN);
	localparam logic [7:0] MARKER     = `STR_MARKER;
	localparam logic [7:0] MAX_LEN    = 8'(`STR_MAX_LEN);
	localparam logic [7:0] MAX_LEN_M1 = 8'(`STR_MAX_LEN - 1);

	localparam logic [5:0] SR_HUNT    = 6'b00_0001,
	                       SR_OPEN    = 6'b00_0010,
	                       SR_CONTENT = 6'b00_0100,
	                       SR_PEND    = 6'b00_1000,
	                       SR_CLOSE   = 6'b01_0000,
	                       SR_FINISH  = 6'b10_0000;

	logic [5:0]         state;
	logic               mark_vld;
	logic               data_vld;
	logic               room1;                                   // Space for one more byte
	logic               room2;                                   // Space for two more bytes
	logic [IDX_W-1:0]   wr_idx;
	logic [IDX_W-1:0]   wr_idx_nxt;

	assign mark_vld   = byte_vld && (byte_data == MARKER);
	assign data_vld   = byte_vld && (byte_data != MARKER);
	assign room1      = (rx_length < MAX_LEN);
	assign room2      = (rx_length < MAX_LEN_M1);
	assign wr_idx     = rx_length[IDX_W-1:0];
	assign wr_idx_nxt = wr_idx + 1'b1;
	assign rx_busy    = (state != SR_HUNT);
	assign rx_done    = (state == SR_FINISH);

	// ######################################################################
	// Deframing state machine and length
	// ######################################################################
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= SR_HUNT;
			rx_length <= 8'd0;
		end else begin
			case (state)
				SR_HUNT: begin
					if (mark_vld)
						state <= SR_OPEN;
				end
				SR_OPEN: begin
					if (mark_vld) begin
						state     <= SR_CONTENT;
						rx_length <= 8'd0;                       // New string starts here
					end else if (data_vld) begin
						state <= SR_HUNT;                        // The pair must be back to back
					end
				end
				SR_CONTENT: begin
					if (mark_vld)
						state <= SR_PEND;
					else if (data_vld && room1)
						rx_length <= rx_length + 8'd1;
				end
				SR_PEND: begin
					if (mark_vld) begin
						state <= SR_CLOSE;
					end else if (data_vld) begin
						state <= SR_CONTENT;
						if (room2)
							rx_length <= rx_length + 8'd2;
						else if (room1)
							rx_length <= rx_length + 8'd1;
					end
				end
				SR_CLOSE: state <= SR_FINISH;
				default:  state <= SR_HUNT;
			endcase
		end
	end

	// ######################################################################
	// String buffer
	// ######################################################################
	always_ff @(posedge sys_clk) begin
		if (state == SR_CONTENT && data_vld && room1)
			rx_string.bytes[wr_idx] <= byte_data;
		if (state == SR_PEND && data_vld) begin
			if (room1)
				rx_string.bytes[wr_idx] <= MARKER;                // The held "&" was data after all
			if (room2)
				rx_string.bytes[wr_idx_nxt] <= byte_data;
		end
	end

	a_len_limit: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= MAX_LEN
	) else $error("str_frame_rx: rx_length %0d is beyond the buffer size", rx_length);

endmodule

`default_nettype wire

// ==== logic/uart_string_handle.sv ====
// UART string link top level
// Sends and receives "&&payload&&" strings over one serial line pair using
// the framer, deframer and the byte-level UART transmitter and receiver

`timescale 1ns/1ns
`default_nettype none

`include "uart_str_defs.svh"

module uart_string_handle import uart_str_pkg::*; #(
	parameter int BAUD_RATE = `UART_BAUD_RATE
) (
	input  wire             sys_clk,
	input  wire             sys_rst_n,

	input  wire str_buf_u   tx_string,
	input  wire  [7:0]      tx_length,
	input  wire             tx_req,
	output wire             tx_busy,
	output wire             tx_done,

	output wire str_buf_u   rx_string,
	output wire  [7:0]      rx_length,
	output wire             rx_busy,
	output wire             rx_done,

	input  wire             uart_rx_port,
	output wire             uart_tx_port
);

	localparam int BIT_CYCLES = `UART_CLK_FREQ / BAUD_RATE;        // Clocks per bit at this rate

	wire [7:0]  tx_byte_data;
	wire        tx_byte_req;
	wire        tx_byte_done;
	wire [7:0]  rx_byte_data;
	wire        rx_byte_vld;

	// ######################################################################
	// Transmit path
	// ######################################################################
	str_frame_tx ins_str_frame_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_data  (tx_byte_data),
		.byte_req   (tx_byte_req),
		.byte_done  (tx_byte_done)
	);

	uart_tx #(
		.BIT_CYCLES (BIT_CYCLES),
		.STOP_BITS  (`UART_TX_STOP_BITS)
	) ins_uart_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (tx_byte_data),
		.byte_req   (tx_byte_req),
		.tx         (uart_tx_port),
		.byte_done  (tx_byte_done)
	);

	// ######################################################################
	// Receive path
	// ######################################################################
	uart_rx #(
		.BIT_CYCLES (BIT_CYCLES)
	) ins_uart_rx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx         (uart_rx_port),
		.byte_data  (rx_byte_data),
		.byte_vld   (rx_byte_vld)
	);

	str_frame_rx ins_str_frame_rx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (rx_byte_data),
		.byte_vld   (rx_byte_vld),
		.rx_string  (rx_string),
		.rx_length  (rx_length),
		.rx_busy    (rx_busy),
		.rx_done    (rx_done)
	);

endmodule

`default_nettype wire

// ==== test/tb_uart_string_ref.svh ====
// UART string link reference model
// Framing and deframing rules of the string link, random payloads and the
// typed compare tasks, included inside the testbench module

`ifndef TB_UART_STRING_REF_SVH
`define TB_UART_STRING_REF_SVH

typedef logic [7:0] byte_q_t [$];

localparam logic [7:0] REF_MARKER  = `STR_MARKER;
localparam int         REF_MAX_LEN = `STR_MAX_LEN;

localparam int REF_HUNT = 0;                                 // Waiting for the first marker
localparam int REF_OPEN = 1;                                 // One marker seen
localparam int REF_DATA = 2;                                 // Inside the payload
localparam int REF_PEND = 3;                                 // Marker held inside the payload

// ######################################################################
// Reference framing
// ######################################################################
function automatic void frame_bytes(input byte_q_t payload, output byte_q_t framed);
	framed = {REF_MARKER, REF_MARKER};
	foreach (payload[i])
		framed.push_back(payload[i]);
	framed.push_back(REF_MARKER);
	framed.push_back(REF_MARKER);
endfunction

// Result of the last complete frame in the stream, with the frame count
function automatic void deframe(input byte_q_t stream, output str_buf_u exp_str,
		output logic [7:0] exp_len, output int frames);
	str_buf_u   acc;
	int         len;
	int         st;
	logic [7:0] b;
	acc     = '0;
	len     = 0;
	st      = REF_HUNT;
	frames  = 0;
	exp_str = '0;
	exp_len = 8'd0;
	foreach (stream[i]) begin
		b = stream[i];
		case (st)
			REF_HUNT: begin
				if (b == REF_MARKER)
					st = REF_OPEN;
			end
			REF_OPEN: begin
				st  = (b == REF_MARKER) ? REF_DATA : REF_HUNT;  // Pair must be back to back
				len = 0;
			end
			REF_DATA: begin
				if (b == REF_MARKER) begin
					st = REF_PEND;
				end else if (len < REF_MAX_LEN) begin
					acc.bytes[len] = b;
					len++;
				end
			end
			default: begin
				if (b == REF_MARKER) begin
					st      = REF_HUNT;
					frames++;
					exp_str = acc;
					exp_len = 8'(len);
				end else begin
					st = REF_DATA;
					if (len < REF_MAX_LEN) begin
						acc.bytes[len] = REF_MARKER;                 // A lone marker is data
						len++;
					end
					if (len < REF_MAX_LEN) begin
						acc.bytes[len] = b;
						len++;
					end
				end
			end
		endcase
	end
endfunction

// Printable bytes with some lone markers, never a pair and never a trailing one
function automatic void random_payload(input int len, output byte_q_t q);
	logic [7:0] b;
	q = {};
	for (int k = 0; k < len; k++) begin
		b = 8'h20 + 8'($unsigned($random(seed)) % 95);
		if ($unsigned($random(seed)) % 6 == 0)
			b = REF_MARKER;
		if (b == REF_MARKER && (k == len - 1 || (k > 0 && q[k-1] == REF_MARKER)))
			b = 8'h2a;
		q.push_back(b);
	end
endfunction

function automatic str_buf_u pack_string(input byte_q_t q);
	str_buf_u s;
	s = '0;
	foreach (q[i]) begin
		if (i < REF_MAX_LEN)
			s.bytes[i] = q[i];
	end
	return s;
endfunction

function automatic void unpack_string(input str_buf_u s, input logic [7:0] len,
		output byte_q_t q);
	q = {};
	for (int k = 0; k < int'(len); k++)
		q.push_back(s.bytes[k]);
endfunction

// ######################################################################
// Compare tasks
// ######################################################################
task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
		report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_length(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
endtask

// Only the first len characters carry the string
task automatic check_string(input string name, input str_buf_u got, input str_buf_u exp,
		input logic [7:0] len);
	for (int k = 0; k < int'(len); k++) begin
		if (got.bytes[k] !== exp.bytes[k])
			report_failure($sformatf("CHECK FAILED %s.bytes[%0d] got 0x%h expected 0x%h",
				name, k, got.bytes[k], exp.bytes[k]));
	end
endtask

`endif

// ==== test/tb_uart_string.sv ====
// UART string link testbench
// Drives framed strings into the receive line, decodes the transmit line and
// compares both directions with the reference framing model

`timescale 1ns/1ns
`default_nettype none

`include "uart_str_defs.svh"

module tb_uart_string import uart_str_pkg::*; ();

	localparam int BIT      = `UART_BIT_CYCLES;
	localparam int N_DUPLEX = 20;
	// Framed bytes per direction over all tests, full duplex at full length
	localparam int TX_BYTES = (5 + 4) + (1 + 4) + (60 + 4) + (128 + 4) + N_DUPLEX * (128 + 4);
	localparam int RX_BYTES = (11 + 4) + (7 + 4) + (4 + 5 + 4) + (140 + 4) + N_DUPLEX * (128 + 4);
	localparam int TIMEOUT_CYCLES = (TX_BYTES + RX_BYTES) * 11 * BIT * 2 + 100_000;

	logic           sys_clk;
	logic           sys_rst_n;
	str_buf_u       tx_string;
	logic [7:0]     tx_length;
	logic           tx_req;
	logic           tx_busy;
	logic           tx_done;
	str_buf_u       rx_string;
	logic [7:0]     rx_length;
	logic           rx_busy;
	logic           rx_done;
	logic           uart_rx_port;
	logic           uart_tx_port;

	integer         seed;
	int             cycle_cnt;
	int             tx_done_count = 0;
	int             rx_done_count = 0;
	logic           tx_done_q = 1'b0;
	logic           tx_busy_q = 1'b0;
	logic           rx_done_q = 1'b0;
	logic           rx_busy_q = 1'b0;
	logic [7:0]     exp_tx_bytes[$];                         // Framed bytes still to appear
	str_buf_u       exp_rx_str[$];
	logic [7:0]     exp_rx_len[$];
	str_buf_u       dup_tx_str[N_DUPLEX];
	logic [7:0]     dup_tx_len[N_DUPLEX];
	str_buf_u       dup_rx_str[N_DUPLEX];
	logic [7:0]     dup_rx_len[N_DUPLEX];

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	`include "tb_uart_string_ref.svh"

	uart_string_handle #(
		.BAUD_RATE    (`UART_BAUD_RATE)
	) uart_string_handle_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	initial begin : watchdog
		cycle_cnt = 0;
		forever begin
			@(posedge sys_clk);
			cycle_cnt++;
			if (cycle_cnt >= TIMEOUT_CYCLES)
				report_failure($sformatf("Timeout after %0d cycles, the tests did not finish",
					cycle_cnt));
		end
	end

	// ######################################################################
	// Serial line models
	// ######################################################################
	// Called just after a rising edge; one stop bit per byte
	task automatic drive_byte(input logic [7:0] b);
		uart_rx_port <= 1'b0;
		repeat (BIT) @(posedge sys_clk);
		for (int k = 0; k < 8; k++) begin
			uart_rx_port <= b[k];                            // LSB first
			repeat (BIT) @(posedge sys_clk);
		end
		uart_rx_port <= 1'b1;
		repeat (BIT) @(posedge sys_clk);
	endtask

	task automatic drive_stream(input byte_q_t stream);
		foreach (stream[i])
			drive_byte(stream[i]);
	endtask

	// Decodes uart_tx_port at mid-bit on falling edges and compares each byte
	initial begin : tx_monitor
		logic [7:0] data;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n && !uart_tx_port) begin
				repeat (BIT / 2) @(negedge sys_clk);
				if (uart_tx_port)
					report_failure("Start bit on uart_tx_port did not stay low to its middle");
				for (int k = 0; k < 8; k++) begin
					repeat (BIT) @(negedge sys_clk);
					data[k] = uart_tx_port;
				end
				repeat (BIT) @(negedge sys_clk);
				if (!uart_tx_port)
					report_failure("Stop bit on uart_tx_port was low");
				if (exp_tx_bytes.size() == 0)
					report_failure($sformatf("Unexpected byte 0x%h on uart_tx_port", data));
				else
					check_byte("uart_tx_port byte", data, exp_tx_bytes.pop_front());
			end
		end
	end

	// ######################################################################
	// Pulse watchers and receive comparison
	// ######################################################################
	always @(negedge sys_clk) begin : tx_watch
		if (sys_rst_n) begin
			if (tx_done)
				tx_done_count++;
			if (tx_done && tx_done_q)
				report_failure("tx_done stayed high for more than one cycle");
			if (tx_done_q && tx_busy)
				report_failure("tx_busy stuck high after tx_done");
			if (tx_busy_q && !tx_busy && !tx_done_q)
				report_failure("tx_busy fell before tx_done");
		end
		tx_done_q = tx_done;
		tx_busy_q = tx_busy;
	end

	always @(negedge sys_clk) begin : rx_compare
		str_buf_u   exp_str;
		logic [7:0] exp_len;
		if (sys_rst_n && rx_done) begin
			rx_done_count++;
			if (rx_done_q)
				report_failure("rx_done stayed high for more than one cycle");
			if (!rx_busy_q)
				report_failure("rx_busy was low while the closing markers arrived");
			if (exp_rx_len.size() == 0)
				report_failure("rx_done pulsed with no string expected");
			exp_str = exp_rx_str.pop_front();
			exp_len = exp_rx_len.pop_front();
			check_length("rx_length", rx_length, exp_len);
			check_string("rx_string", rx_string, exp_str, exp_len);
		end
		if (sys_rst_n && rx_done_q && rx_busy)
			report_failure("rx_busy stuck high after rx_done");
		rx_done_q = rx_done;
		rx_busy_q = rx_busy;
	end

	// ######################################################################
	// Test tasks
	// ######################################################################
	task automatic transmit_string(input byte_q_t payload, input bit extra_req);
		byte_q_t framed;
		int      start_count;
		int      limit;
		int      waited;
		frame_bytes(payload, framed);
		foreach (framed[i])
			exp_tx_bytes.push_back(framed[i]);
		start_count = tx_done_count;
		limit       = framed.size() * 11 * BIT * 2 + 1000;
		tx_string <= pack_string(payload);
		tx_length <= 8'(payload.size());
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		@(negedge sys_clk);
		check_flag("tx_busy", tx_busy, 1'b1);                // Rises in the cycle after acceptance
		if (extra_req) begin
			repeat (10 * BIT) @(posedge sys_clk);
			tx_string <= '1;                                 // Must not start a second frame
			tx_length <= 8'd3;
			tx_req    <= 1'b1;
			@(posedge sys_clk);
			tx_req <= 1'b0;
		end
		waited = 0;
		while (tx_done_count == start_count) begin
			@(posedge sys_clk);
			waited++;
			if (waited > limit)
				report_failure("tx_done never arrived for a requested frame");
		end
		if (exp_tx_bytes.size() != 0)
			report_failure($sformatf("%0d framed bytes were missing on uart_tx_port at tx_done",
				exp_tx_bytes.size()));
	endtask

	task automatic receive_string(input byte_q_t stream);
		str_buf_u   exp_str;
		logic [7:0] exp_len;
		int         frames;
		int         start_count;
		int         waited;
		deframe(stream, exp_str, exp_len, frames);
		if (frames != 1)
			report_failure("Driven stream does not hold exactly one complete frame");
		exp_rx_str.push_back(exp_str);
		exp_rx_len.push_back(exp_len);
		start_count = rx_done_count;
		drive_stream(stream);
		waited = 0;
		while (rx_done_count == start_count) begin
			@(posedge sys_clk);
			waited++;
			if (waited > 4 * BIT)
				report_failure("rx_done never arrived after the closing markers");
		end
		repeat (2 * BIT) @(posedge sys_clk);                 // Idle gap on the line
		if (rx_done_count != start_count + 1)
			report_failure("rx_done pulsed more than once for one frame");
	endtask

	// ######################################################################
	// Test sequence
	// ######################################################################
	initial begin : test_seq
		byte_q_t payload;
		byte_q_t stream;
		byte_q_t framed;
		int      len;
		int      start_count;
		seed         = 32'hbe29_60c0;
		sys_rst_n    = 1'b0;
		tx_string    = '0;
		tx_length    = 8'd0;
		tx_req       = 1'b0;
		uart_rx_port = 1'b1;
		repeat (16) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (4) @(posedge sys_clk);

		// State after reset, and a request with zero length
		@(negedge sys_clk);
		check_flag("uart_tx_port", uart_tx_port, 1'b1);
		check_flag("tx_busy", tx_busy, 1'b0);
		check_flag("tx_done", tx_done, 1'b0);
		check_flag("rx_busy", rx_busy, 1'b0);
		check_flag("rx_done", rx_done, 1'b0);
		check_length("rx_length", rx_length, 8'd0);
		@(posedge sys_clk);
		tx_string <= '1;
		tx_length <= 8'd0;
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		check_flag("tx_busy", tx_busy, 1'b0);
		@(posedge sys_clk);

		// Transmit framing, one request arrives while busy
		payload = {8'h48, 8'h65, 8'h6c, 8'h6c, 8'h6f};
		transmit_string(payload, 1'b0);
		payload = {8'h21};
		transmit_string(payload, 1'b0);
		random_payload(60, payload);
		transmit_string(payload, 1'b1);
		random_payload(128, payload);
		transmit_string(payload, 1'b0);
		start_count = tx_done_count;
		repeat (15 * BIT) @(posedge sys_clk);
		if (tx_done_count != start_count)
			report_failure("A frame was sent without a request");
		@(negedge sys_clk);
		check_flag("tx_busy", tx_busy, 1'b0);
		@(posedge sys_clk);

		// Plain receive
		payload = {8'h48, 8'h65, 8'h6c, 8'h6c, 8'h6f, 8'h20, 8'h77, 8'h6f, 8'h72, 8'h6c, 8'h64};
		frame_bytes(payload, stream);
		receive_string(stream);

		// Lone markers, noise before the opening pair, and an oversized payload
		payload = {8'h61, 8'h26, 8'h62, 8'h26, 8'h63, 8'h26, 8'h64};
		frame_bytes(payload, stream);
		receive_string(stream);
		payload = {8'h48, 8'h69, 8'h26, 8'h79, 8'h6f};
		frame_bytes(payload, framed);
		stream = {8'h78, 8'h79, 8'h26, 8'h7a};
		stream = {stream, framed};
		receive_string(stream);
		random_payload(140, payload);
		frame_bytes(payload, stream);
		receive_string(stream);

		// Full duplex with random strings, all drawn before the two sides start
		for (int i = 0; i < N_DUPLEX; i++) begin
			len = 1 + int'($unsigned($random(seed)) % REF_MAX_LEN);
			random_payload(len, payload);
			dup_tx_str[i] = pack_string(payload);
			dup_tx_len[i] = 8'(len);
			len = 1 + int'($unsigned($random(seed)) % REF_MAX_LEN);
			random_payload(len, payload);
			dup_rx_str[i] = pack_string(payload);
			dup_rx_len[i] = 8'(len);
		end
		fork
			begin : dup_tx
				byte_q_t q;
				for (int n = 0; n < N_DUPLEX; n++) begin
					unpack_string(dup_tx_str[n], dup_tx_len[n], q);
					transmit_string(q, 1'b0);
				end
			end
			begin : dup_rx
				byte_q_t q;
				byte_q_t s;
				for (int n = 0; n < N_DUPLEX; n++) begin
					unpack_string(dup_rx_str[n], dup_rx_len[n], q);
					frame_bytes(q, s);
					receive_string(s);
				end
			end
		join

		repeat (10) @(posedge sys_clk);
		if (exp_rx_len.size() != 0 || exp_tx_bytes.size() != 0) begin
			report_failure("Expected results were left unchecked at the end of the run");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
+incdir+test
logic/uart_str_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/str_frame_tx.sv
logic/str_frame_rx.sv
logic/uart_string_handle.sv
test/tb_uart_string.sv
